/* logic/nocPkg.sv */
`default_nettype none

package nocPkg;

  // Port order is also the round-robin order.
  localparam int NUM_PORTS = 5;
  localparam int PORT_W = 3;
  localparam int FLIT_W = 32;
  localparam int LEN_W = 12;

  localparam int PORT_LOCAL = 0;
  localparam int PORT_NORTH = 1;
  localparam int PORT_EAST = 2;
  localparam int PORT_WEST = 3;
  localparam int PORT_SOUTH = 4;

  typedef enum logic [1:0] {
    FK_IDLE = 2'd0,
    FK_HEAD = 2'd1,
    FK_BODY = 2'd2,
    FK_TAIL = 2'd3
  } flitKindE;

  // Header view of a flit. Length counts head and tail.
  typedef struct packed {
    flitKindE kind;
    logic [3:0] dest;
    logic [LEN_W-1:0] length;
    logic [13:0] rsvd;
  } headFieldsT;

  // Body view of a flit, used for body and tail words.
  typedef struct packed {
    flitKindE kind;
    logic [29:0] payload;
  } bodyFieldsT;

  // The kind field sits in the same bits in both views.
  typedef union packed {
    headFieldsT head;
    bodyFieldsT body;
  } flitWordU;

endpackage

`default_nettype wire

/* logic/portReqIf.sv */
`timescale 1ns/1ps
`default_nettype none

// Decoded request of one input port, from its decoder to the arbiter.
interface portReqIf;
  import nocPkg::*;

  logic req;   // Flit belongs to a packet.
  logic head;  // Flit opens a packet.
  logic tail;  // Flit closes a packet.
  logic [LEN_W-1:0] length;
  logic take;  // Flit moves this cycle.
  logic close; // Packet ended by the hold timer.

  modport dec (
    output req,
    output head,
    output tail,
    output length,
    input take,
    input close
  );

  modport arb (
    input req,
    input head,
    input tail,
    input length,
    output take,
    output close
  );

endinterface

`default_nettype wire

/* logic/flitDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module flitDecoder (
  input logic clk,
  input logic rst,
  input logic valid,
  input nocPkg::flitWordU flit,
  output logic ready,
  portReqIf.dec link
);
  import nocPkg::*;

  logic inPkt;
  logic stray;
  flitKindE kind;

  assign kind = flit.body.kind;

  // Outside a packet only a head flit may request the output.
  assign link.req = valid && (inPkt || kind == FK_HEAD);
  assign link.head = !inPkt && kind == FK_HEAD;
  assign link.tail = inPkt && kind == FK_TAIL;
  assign link.length = link.head ? flit.head.length : '0;

  // Anything else outside a packet is accepted and dropped at once.
  assign stray = valid && !inPkt && kind != FK_HEAD;

  assign ready = link.take || stray;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      inPkt <= 1'b0;
    end
    else
    begin
      if (link.take && link.head)
      begin
        inPkt <= 1'b1;
      end
      // Closing wins, so a one-flit packet leaves the bit clear.
      if (link.close || (link.take && link.tail))
      begin
        inPkt <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/holdTimer.sv */
`timescale 1ns/1ps
`default_nettype none

module holdTimer (
  input logic clk,
  input logic rst,
  input logic load,
  input logic [nocPkg::LEN_W-1:0] length,
  input logic step,
  output logic last
);
  import nocPkg::*;

  logic [LEN_W-1:0] remain; // Flits still allowed after the ones taken.

  // On the head flit itself the decision comes from the length field.
  assign last = load ? (length <= LEN_W'(1)) : (remain == LEN_W'(1));

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      remain <= '0;
    end
    else if (load)
    begin
      remain <= (length == '0) ? '0 : length - 1'b1; // The head is flit one.
    end
    else if (step && remain != '0)
    begin
      remain <= remain - 1'b1;
    end
  end

endmodule

`default_nettype wire

/* logic/portArbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module portArbiter (
  input logic clk,
  input logic rst,
  portReqIf.arb links [nocPkg::NUM_PORTS],
  input logic space,
  output logic [nocPkg::PORT_W-1:0] grant,
  output logic move
);
  import nocPkg::*;

  logic busy;
  logic [PORT_W-1:0] rrPtr; // First port searched on the next arbitration.
  logic [PORT_W-1:0] pick;
  logic found;
  logic endPkt;

  logic [NUM_PORTS-1:0] reqV;
  logic [NUM_PORTS-1:0] headV;
  logic [NUM_PORTS-1:0] tailV;
  logic [NUM_PORTS-1:0] lastV;
  logic [NUM_PORTS-1:0] takeV;
  logic [NUM_PORTS-1:0] closeV;

  for (genvar p = 0; p < NUM_PORTS; p++)
  begin : gPort
    assign reqV[p] = links[p].req;
    assign headV[p] = links[p].head;
    assign tailV[p] = links[p].tail;
    assign links[p].take = takeV[p];
    assign links[p].close = closeV[p];

    holdTimer u_timer (
      .clk    (clk),
      .rst    (rst),
      .load   (takeV[p] && headV[p]),
      .length (links[p].length),
      .step   (takeV[p]),
      .last   (lastV[p])
    );
  end

  // Round-robin search for a head flit, starting at rrPtr and wrapping.
  always_comb
  begin
    int cand;
    found = 1'b0;
    pick = '0;
    for (int i = 0; i < NUM_PORTS; i++)
    begin
      cand = int'(rrPtr) + i;
      if (cand >= NUM_PORTS)
      begin
        cand = cand - NUM_PORTS;
      end
      if (!found && reqV[cand] && headV[cand])
      begin
        found = 1'b1;
        pick = PORT_W'(cand);
      end
    end
  end

  assign move = busy && reqV[grant] && space;

  always_comb
  begin
    takeV = '0;
    closeV = '0;
    takeV[grant] = move;
    closeV[grant] = move && lastV[grant]; // Timer expiry ends the packet.
  end

  assign endPkt = move && (tailV[grant] || lastV[grant]);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      busy <= 1'b0;
      grant <= '0;
      rrPtr <= '0;
    end
    else if (!busy)
    begin
      if (found)
      begin
        busy <= 1'b1;
        grant <= pick;
        rrPtr <= (pick == PORT_W'(NUM_PORTS - 1)) ? '0 : pick + 1'b1;
      end
    end
    else if (endPkt)
    begin
      busy <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* logic/outputStage.sv */
`timescale 1ns/1ps
`default_nettype none

module outputStage (
  input logic clk,
  input logic rst,
  input nocPkg::flitWordU inFlit [nocPkg::NUM_PORTS],
  input logic [nocPkg::PORT_W-1:0] grant,
  input logic move,
  output logic space,
  output logic outValid,
  output nocPkg::flitWordU outFlit,
  output logic [nocPkg::PORT_W-1:0] outPort,
  input logic outReady
);
  import nocPkg::*;

  flitWordU selFlit;

  // The register can take a flit when empty or while it drains.
  assign space = !outValid || outReady;

  always_comb
  begin
    selFlit = '0;
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      if (grant == PORT_W'(p))
      begin
        selFlit = inFlit[p];
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
    end
    else if (move)
    begin
      outValid <= 1'b1;
    end
    else if (outReady)
    begin
      outValid <= 1'b0; // Drained with nothing behind it.
    end
  end

  always_ff @(posedge clk)
  begin
    if (move)
    begin
      outFlit <= selFlit;
      outPort <= grant;
    end
  end

endmodule

`default_nettype wire

/* logic/routerArbTop.sv */
`timescale 1ns/1ps
`default_nettype none

module routerArbTop (
  input logic clk,
  input logic rst,
  input logic [nocPkg::NUM_PORTS-1:0] inValid,
  input nocPkg::flitWordU inFlit [nocPkg::NUM_PORTS],
  output logic [nocPkg::NUM_PORTS-1:0] inReady,
  output logic outValid,
  output nocPkg::flitWordU outFlit,
  output logic [nocPkg::PORT_W-1:0] outPort,
  input logic outReady
);
  import nocPkg::*;

  logic [PORT_W-1:0] grant;
  logic move;
  logic space;

  portReqIf links [NUM_PORTS] ();

  // One decoder per input port, local first.
  for (genvar p = 0; p < NUM_PORTS; p++)
  begin : gDec
    flitDecoder u_dec (
      .clk   (clk),
      .rst   (rst),
      .valid (inValid[p]),
      .flit  (inFlit[p]),
      .ready (inReady[p]),
      .link  (links[p])
    );
  end

  portArbiter u_arb (
    .clk   (clk),
    .rst   (rst),
    .links (links),
    .space (space),
    .grant (grant),
    .move  (move)
  );

  outputStage u_out (
    .clk      (clk),
    .rst      (rst),
    .inFlit   (inFlit),
    .grant    (grant),
    .move     (move),
    .space    (space),
    .outValid (outValid),
    .outFlit  (outFlit),
    .outPort  (outPort),
    .outReady (outReady)
  );

endmodule

`default_nettype wire

/* dv/clockGen.sv */
`timescale 1ns/1ps
`default_nettype none

module clockGen (
  output logic clk,
  output logic rst
);

  localparam int HALF_NS = 10;
  localparam int RESET_CYCLES = 8;

  initial
  begin
    clk = 1'b0;
    forever #(HALF_NS) clk = ~clk;
  end

  // Reset is released on a falling edge, away from the edge the DUT samples.
  initial
  begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

`default_nettype wire

/* dv/routerArbTb.sv */
`timescale 1ns/1ps
`default_nettype none

module routerArbTb;
  import nocPkg::*;

  logic clk;
  logic rst;
  logic [NUM_PORTS-1:0] inValid;
  flitWordU inFlit [NUM_PORTS];
  logic [NUM_PORTS-1:0] inReady;
  logic outValid;
  flitWordU outFlit;
  logic [PORT_W-1:0] outPort;
  logic outReady;

  flitWordU portQ [NUM_PORTS][$];     // Flits still to be offered on each port.
  flitWordU pendFlits [NUM_PORTS][$]; // Flits that should reach the output.
  int pendLen [NUM_PORTS][$];         // Forwarded flit count per queued packet.
  flitWordU expFlits[$];
  logic [PORT_W-1:0] expPorts[$];
  flitWordU gotFlits[$];
  logic [PORT_W-1:0] gotPorts[$];

  int nextPort = 0; // Round-robin model of the arbiter.
  int cycles = 0;
  int totalFlits = 0;
  int errCount = 0;
  int checks = 0;
  int testsRun = 0;
  int testsFailed = 0;
  int takeCycle = 0;
  int outCycle = 0;
  bit sawTake = 0;
  bit sawOutput = 0;
  bit stallOn = 0;

  clockGen u_clk (
    .clk (clk),
    .rst (rst)
  );

  routerArbTop u_dut (
    .clk      (clk),
    .rst      (rst),
    .inValid  (inValid),
    .inFlit   (inFlit),
    .inReady  (inReady),
    .outValid (outValid),
    .outFlit  (outFlit),
    .outPort  (outPort),
    .outReady (outReady)
  );

  always @(negedge clk)
  begin
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      inValid[p] = portQ[p].size() > 0;
      inFlit[p] = (portQ[p].size() > 0) ? portQ[p][0] : '0;
    end
    outReady = stallOn ? (($urandom % 4) != 0) : 1'b1; // Stalls about one cycle in four.
  end

  // Input and output monitor, plus the cycle limit.
  always @(posedge clk)
  begin
    if (!rst)
    begin
      for (int p = 0; p < NUM_PORTS; p++)
      begin
        if (inValid[p] && inReady[p])
        begin
          if (!sawTake && inFlit[p].body.kind == FK_HEAD)
          begin
            sawTake = 1'b1;
            takeCycle = cycles;
          end
          if (portQ[p].size() > 0)
          begin
            void'(portQ[p].pop_front());
          end
        end
      end
      if (outValid && !sawOutput)
      begin
        sawOutput = 1'b1;
        outCycle = cycles;
      end
      if (outValid && outReady)
      begin
        gotFlits.push_back(outFlit);
        gotPorts.push_back(outPort);
      end
    end
    cycles++;
    if (cycles > totalFlits * 4 + 500)
    begin
      $display("Run stopped: the DUT made no progress within %0d cycles.", cycles);
      $display(">>> FAIL");
      $finish;
    end
  end

  function automatic flitWordU makeHead(input int port, input int lenField);
    flitWordU w;
    w = '0;
    w.head.kind = FK_HEAD;
    w.head.dest = 4'(port);
    w.head.length = LEN_W'(lenField);
    w.head.rsvd = 14'($urandom);
    return w;
  endfunction

  function automatic flitWordU makeData(input flitKindE kind);
    flitWordU w;
    w.body.kind = kind;
    w.body.payload = 30'($urandom);
    return w;
  endfunction

  // A packet of nFlits flits whose head says lenField; only the first lenField get through.
  task automatic queuePacket(input int port, input int nFlits, input int lenField);
    flitWordU w;
    int fwd;
    fwd = (lenField < nFlits) ? lenField : nFlits;
    for (int i = 0; i < nFlits; i++)
    begin
      if (i == 0)
        w = makeHead(port, lenField);
      else if (i == nFlits - 1)
        w = makeData(FK_TAIL);
      else
        w = makeData(FK_BODY);
      portQ[port].push_back(w);
      if (i < fwd)
        pendFlits[port].push_back(w);
    end
    pendLen[port].push_back(fwd);
    totalFlits += nFlits;
  endtask

  task automatic queueStrays(input int port, input int n);
    for (int i = 0; i < n; i++)
    begin
      portQ[port].push_back(makeData((i % 2 == 0) ? FK_BODY : FK_TAIL));
    end
    totalFlits += n;
  endtask

  // Whole packets leave in round-robin order from the port after the last winner.
  task automatic buildExpected();
    bit more;
    int port;
    int n;
    more = 1'b1;
    while (more)
    begin
      more = 1'b0;
      port = 0;
      for (int i = 0; i < NUM_PORTS; i++)
      begin
        if (!more && pendLen[(nextPort + i) % NUM_PORTS].size() > 0)
        begin
          more = 1'b1;
          port = (nextPort + i) % NUM_PORTS;
        end
      end
      if (more)
      begin
        n = pendLen[port].pop_front();
        repeat (n)
        begin
          expFlits.push_back(pendFlits[port].pop_front());
          expPorts.push_back(PORT_W'(port));
        end
        nextPort = (port + 1) % NUM_PORTS;
      end
    end
  endtask

  task automatic waitDrained();
    bit done;
    buildExpected();
    done = 1'b0;
    while (!done)
    begin
      @(negedge clk);
      done = !outValid && gotFlits.size() >= expFlits.size();
      for (int p = 0; p < NUM_PORTS; p++)
      begin
        if (portQ[p].size() != 0)
          done = 1'b0;
      end
    end
    repeat (3) @(negedge clk); // Room for a duplicate flit to show up.
  endtask

  task automatic reportProblem(input string msg);
    errCount++;
    $display("Check failed at %0t ns: %s.", $time, msg);
  endtask

  task automatic checkFlit(input string name, input flitWordU got, input flitWordU exp);
    checks++;
    if (got !== exp)
    begin
      errCount++;
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic checkPort(input string name, input logic [PORT_W-1:0] got,
                           input logic [PORT_W-1:0] exp);
    checks++;
    if (got !== exp)
    begin
      errCount++;
      $display("ERROR at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic compareOutput();
    int n;
    if (gotFlits.size() != expFlits.size())
      reportProblem($sformatf("%0d flits came out where %0d were expected",
                              gotFlits.size(), expFlits.size()));
    n = (gotFlits.size() < expFlits.size()) ? gotFlits.size() : expFlits.size();
    for (int i = 0; i < n; i++)
    begin
      checkFlit("outFlit", gotFlits[i], expFlits[i]);
      checkPort("outPort", gotPorts[i], expPorts[i]);
    end
    gotFlits.delete();
    gotPorts.delete();
    expFlits.delete();
    expPorts.delete();
  endtask

  task automatic finishTest(input int num, input string name, input int errStart);
    compareOutput();
    testsRun++;
    if (errCount == errStart)
      $display("Test %0d %s: passed", num, name);
    else
    begin
      testsFailed++;
      $display("Test %0d %s: failed with %0d errors", num, name, errCount - errStart);
    end
  endtask

  task automatic testResetLatency();
    int errStart;
    errStart = errCount;
    if (outValid !== 1'b0)
      reportProblem("outValid is not low after reset");
    if (inReady !== '0)
      reportProblem("an inReady is not low after reset");
    @(posedge clk);
    queuePacket(PORT_LOCAL, 3, 3);
    waitDrained();
    if (!sawTake || !sawOutput || outCycle - takeCycle != 1)
      reportProblem("the first flit did not come out one cycle after its head was taken");
    finishTest(1, "reset and latency", errStart);
  endtask

  task automatic testEachPort();
    int errStart;
    errStart = errCount;
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      @(posedge clk);
      queuePacket(p, 2 + p, 2 + p);
      waitDrained();
    end
    finishTest(2, "one packet per port", errStart);
  endtask

  task automatic testRoundRobin();
    int errStart;
    errStart = errCount;
    @(posedge clk);
    for (int p = 0; p < NUM_PORTS; p++)
      queuePacket(p, 4, 4);
    waitDrained();
    @(posedge clk);
    queuePacket(PORT_NORTH, 3, 3); // Moves the pointer to east.
    waitDrained();
    @(posedge clk);
    for (int p = 0; p < NUM_PORTS; p++)
      queuePacket(p, 3, 3);
    waitDrained();
    finishTest(3, "round-robin order", errStart);
  endtask

  task automatic testStallTraffic();
    int errStart;
    int len;
    errStart = errCount;
    @(posedge clk);
    stallOn = 1'b1;
    for (int k = 0; k < 2; k++)
    begin
      for (int p = 0; p < NUM_PORTS; p++)
      begin
        len = 2 + int'($urandom % 6);
        queuePacket(p, len, len);
      end
    end
    waitDrained();
    stallOn = 1'b0;
    finishTest(4, "output stalls", errStart);
  endtask

  task automatic testLengthExpiry();
    int errStart;
    errStart = errCount;
    @(posedge clk);
    queuePacket(PORT_EAST, 7, 4); // Tail comes three flits after the length runs out.
    queuePacket(PORT_WEST, 3, 3);
    waitDrained();
    finishTest(5, "length expiry", errStart);
  endtask

  task automatic testStrayFlits();
    int errStart;
    errStart = errCount;
    @(posedge clk);
    queueStrays(PORT_NORTH, 2);
    waitDrained();
    @(posedge clk);
    queuePacket(PORT_SOUTH, 8, 8);
    while (gotFlits.size() == 0)
      @(negedge clk);
    @(posedge clk);
    queueStrays(PORT_NORTH, 3);
    // Each stray is accepted in the cycle it is offered.
    repeat (4) @(negedge clk);
    if (portQ[PORT_NORTH].size() != 0)
      reportProblem("stray flits on the north port were not accepted at once");
    waitDrained();
    finishTest(6, "stray flits", errStart);
  endtask

  initial
  begin
    inValid = '0;
    for (int p = 0; p < NUM_PORTS; p++)
      inFlit[p] = '0;
    outReady = 1'b1;
    void'($urandom(32'h777a_b72b));
    @(negedge rst);
    @(negedge clk);
    testResetLatency();
    testEachPort();
    testRoundRobin();
    testStallTraffic();
    testLengthExpiry();
    testStrayFlits();
    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             testsRun, testsFailed, checks, errCount);
    if (errCount == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
logic/nocPkg.sv
logic/portReqIf.sv
logic/flitDecoder.sv
logic/holdTimer.sv
logic/portArbiter.sv
logic/outputStage.sv
logic/routerArbTop.sv
dv/clockGen.sv
dv/routerArbTb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the router allocator testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -f sim.f --top-module routerArbTb -o routerArbSim \
  && ./obj_dir/routerArbSim | tee sim.log \
  || { echo "Build or run failed."; exit 1; }

grep -q "^>>> PASS$" sim.log \
  && echo "Simulation passed." \
  || { echo "Simulation failed."; exit 1; }
